// File: common/lsu_pkg.sv
package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus and data widths
  //////////////////////////////////////////////////////////////////////

  // Data and address width of the core and of the bus
  localparam int XLEN = 32;

  // Byte lanes on the data bus
  localparam int BE_W = XLEN / 8;

  // Byte offset inside one bus word
  localparam int OFS_W = 2;

  //////////////////////////////////////////////////////////////////////
  // Transfer tracking
  //////////////////////////////////////////////////////////////////////

  // Bus transfers that may wait for their response at the same time
  localparam int MAX_OUTSTANDING = 2;

  // Outstanding counter, wide enough to hold MAX_OUTSTANDING
  localparam int CNT_W = 2;

  //////////////////////////////////////////////////////////////////////
  // Access size
  //////////////////////////////////////////////////////////////////////

  // Encoding follows the funct3 size field of the load/store opcodes
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

endpackage

// File: list.f
common/lsu_pkg.sv
request/lsu_request.sv
verilog/lsu_track.sv
response/lsu_rdata_align.sv
verilog/lsu_top.sv
testbench/lsu_checker.sv
testbench/tb_lsu.sv

// File: request/lsu_request.sv
`timescale 1ns/1ps

module lsu_request import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  // Core request, held stable until it is accepted
  input  logic             valid_i,
  input  logic             we_i,
  input  lsu_size_e        size_i,
  input  logic             sext_i,
  input  logic [XLEN-1:0]  base_i,
  input  logic [XLEN-1:0]  offset_i,
  input  logic [XLEN-1:0]  wdata_i,
  // Bus transfer accepted in this cycle
  input  logic             granted_i,
  // Bus fields of the current phase
  output logic [XLEN-1:0]  addr_o,
  output logic [BE_W-1:0]  be_o,
  output logic [XLEN-1:0]  wdata_o,
  // Phase information
  output logic             split_o,
  output logic             second_o,
  output logic [OFS_W-1:0] offset_o
);

  logic [XLEN-1:0]   addr;
  logic [OFS_W-1:0]  ofs;
  logic [XLEN-1:0]   next_word;
  logic [BE_W-1:0]   size_mask;
  logic [2*BE_W-1:0] be_wide;
  logic [2*XLEN-1:0] wdata_wide;
  logic              second_q;

  //////////////////////////////////////////////////////////////////////
  // Address generation
  //////////////////////////////////////////////////////////////////////

  // Effective address, base plus offset
  assign addr = base_i + offset_i;
  assign ofs  = addr[OFS_W-1:0];

  // Word after the one holding the first byte
  assign next_word = {addr[XLEN-1:OFS_W] + 1'b1, {OFS_W{1'b0}}};

  // Second phase goes to the next word, first phase keeps the low bits
  assign addr_o = second_q ? next_word : addr;

  //////////////////////////////////////////////////////////////////////
  // Byte enables
  //////////////////////////////////////////////////////////////////////

  // Lanes touched by an aligned access of this size
  always_comb begin
    case (size_i)
      LSU_BYTE: size_mask = 4'b0001;
      LSU_HALF: size_mask = 4'b0011;
      default:  size_mask = 4'b1111;
    endcase
  end

  // Shift across two words, upper half spills into the next word
  assign be_wide = {{BE_W{1'b0}}, size_mask} << ofs;

  // Low half for the first phase, spill-over for the second
  assign be_o = second_q ? be_wide[2*BE_W-1:BE_W] : be_wide[BE_W-1:0];

  // Access crosses a word boundary when any lane spills over
  // Covers words at offset 1..3 and halfwords at offset 3
  assign split_o = valid_i && !second_q && (|be_wide[2*BE_W-1:BE_W]);

  //////////////////////////////////////////////////////////////////////
  // Store data
  //////////////////////////////////////////////////////////////////////

  // Rotate left by the byte offset
  // Same rotation serves both phases of a split store
  assign wdata_wide = {wdata_i, wdata_i} << {ofs, 3'b000};

  // Quiet bus data on loads
  assign wdata_o = we_i ? wdata_wide[2*XLEN-1:XLEN] : '0;

  //////////////////////////////////////////////////////////////////////
  // Split-phase state
  //////////////////////////////////////////////////////////////////////

  // Set when the first half of a split access is granted
  // Falls again on the grant of the second half
  // Dropped whenever the core has no request, so the next access
  // always starts in the first phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      second_q <= 1'b0;
    end else if (!valid_i) begin
      second_q <= 1'b0;
    end else if (granted_i) begin
      second_q <= split_o;
    end
  end

  assign second_o = second_q;

  // Offset of the whole access, needed again for the load result
  assign offset_o = ofs;

endmodule

// File: response/lsu_rdata_align.sv
`timescale 1ns/1ps

module lsu_rdata_align import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  // Bus response
  input  logic             rvalid_i,
  input  logic [XLEN-1:0]  rdata_i,
  // Context of the transfer being answered
  input  logic             last_i,
  input  logic             we_i,
  input  lsu_size_e        size_i,
  input  logic             sext_i,
  input  logic [OFS_W-1:0] offset_i,
  // Result towards writeback
  output logic             result_valid_o,
  output logic [XLEN-1:0]  result_rdata_o,
  output logic             result_we_o
);

  logic [XLEN-1:0]   rdata_q;
  logic              half_valid_q;
  logic [2*XLEN-1:0] rdata_full;
  logic [2*XLEN-1:0] rdata_aligned;
  logic [XLEN-1:0]   rdata_ext;

  //////////////////////////////////////////////////////////////////////
  // First half of a split load
  //////////////////////////////////////////////////////////////////////

  // Low word of a split load, kept until the second response
  always_ff @(posedge clk) begin
    if (rvalid_i && !last_i && !we_i) begin
      rdata_q <= rdata_i;
    end
  end

  // Marks that rdata_q holds the low word of the access in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_valid_q <= 1'b0;
    end else if (rvalid_i) begin
      half_valid_q <= !last_i && !we_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Realignment
  //////////////////////////////////////////////////////////////////////

  // Split load joins both words
  // Otherwise the word is doubled so bytes wrap into the top lanes
  assign rdata_full = half_valid_q ? {rdata_i, rdata_q} : {rdata_i, rdata_i};

  // First accessed byte moves down to lane 0
  assign rdata_aligned = rdata_full >> {offset_i, 3'b000};

  // Zero or sign extension by access size
  always_comb begin
    case (size_i)
      LSU_BYTE: begin
        rdata_ext = {{(XLEN-8){sext_i && rdata_aligned[7]}}, rdata_aligned[7:0]};
      end
      LSU_HALF: begin
        rdata_ext = {{(XLEN-16){sext_i && rdata_aligned[15]}}, rdata_aligned[15:0]};
      end
      default: begin
        rdata_ext = rdata_aligned[XLEN-1:0];
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////////////////////////

  // One result per core access, on the response of its last phase
  assign result_valid_o = rvalid_i && last_i;
  assign result_rdata_o = rdata_ext;
  assign result_we_o    = we_i;

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run the simulation, then scan its log
verilator --binary --timing -Wno-fatal --top-module tb_lsu -f list.f -o tb_lsu \
  && ./obj_dir/tb_lsu > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && exit 1 || exit 0

// File: testbench/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker import lsu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  // Core side of the DUT
  input  logic            valid_i,
  input  logic            we_i,
  input  lsu_size_e       size_i,
  input  logic            sext_i,
  input  logic [XLEN-1:0] base_i,
  input  logic [XLEN-1:0] offset_i,
  input  logic [XLEN-1:0] wdata_i,
  input  logic            ready_i,
  input  logic            result_valid_i,
  input  logic [XLEN-1:0] result_rdata_i,
  input  logic            result_we_i,
  // Bus side of the DUT
  input  logic            bus_req_i,
  input  logic [XLEN-1:0] bus_addr_i,
  input  logic            bus_we_i,
  input  logic [BE_W-1:0] bus_be_i,
  input  logic [XLEN-1:0] bus_wdata_i,
  input  logic            bus_gnt_i,
  input  logic            bus_rvalid_i,
  // Status towards the testbench top
  output int              errors_o,
  output logic            idle_o
);

  logic [7:0]      ref_mem [64];
  logic            exp_we_q [$];
  logic [XLEN-1:0] exp_data_q [$];
  int              errors;
  logic            idle;
  int              outstanding;
  int              grants;
  logic [7:0]      covered;
  // Bus fields seen while a request waits for its grant
  logic            hold;
  logic [XLEN-1:0] hold_addr;
  logic            hold_we;
  logic [BE_W-1:0] hold_be;
  logic [XLEN-1:0] hold_wdata;

  assign errors_o = errors;
  assign idle_o   = idle;

  task automatic mismatch(input string sig, input logic [31:0] exp_v, input logic [31:0] got_v);
    $display("MISMATCH %s expected %h got %h", sig, exp_v, got_v);
    errors++;
  endtask

  task automatic complain(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sampling at the falling edge, where every DUT signal is settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    logic [31:0] ea;
    logic [31:0] v;
    logic        e_we;
    logic [31:0] e_data;
    int          bytes;
    int          n_exp;
    if (!rst_n) begin
      // Same contents as the bus slave memory after reset
      for (int a = 0; a < 64; a++) begin
        ref_mem[a] = 8'(a * 37 + 11);
      end
      exp_we_q.delete();
      exp_data_q.delete();
      errors      = 0;
      idle        = 1'b1;
      outstanding = 0;
      grants      = 0;
      covered     = '0;
      hold        = 1'b0;
    end else begin
      ea    = base_i + offset_i;
      bytes = 1 << size_i;

      // One result per core access, oldest first
      if (result_valid_i) begin
        if (exp_we_q.size() == 0) begin
          complain("result_valid_o with no access waiting for a result");
        end else begin
          e_we   = exp_we_q.pop_front();
          e_data = exp_data_q.pop_front();
          if (result_we_i !== e_we) begin
            mismatch("result_we_o", 32'(e_we), 32'(result_we_i));
          end else if (!e_we && result_rdata_i !== e_data) begin
            mismatch("result_rdata_o", e_data, result_rdata_i);
          end
        end
      end

      // Request and fields hold until granted
      if (hold && (!bus_req_i || bus_addr_i !== hold_addr || bus_we_i !== hold_we ||
                   bus_be_i !== hold_be || bus_wdata_i !== hold_wdata)) begin
        complain("bus request or its fields changed before the grant");
      end
      hold       = bus_req_i && !bus_gnt_i;
      hold_addr  = bus_addr_i;
      hold_we    = bus_we_i;
      hold_be    = bus_be_i;
      hold_wdata = bus_wdata_i;
      if (ready_i && !(bus_req_i && bus_gnt_i)) begin
        complain("ready_o high in a cycle without a bus grant");
      end

      // Phase addresses and lanes of the access in progress
      if (bus_req_i && bus_gnt_i) begin
        if (bus_we_i !== we_i) begin
          mismatch("bus_we_o", 32'(we_i), 32'(bus_we_i));
        end
        if (grants == 0 && bus_addr_i !== ea) begin
          mismatch("bus_addr_o", ea, bus_addr_i);
        end
        if (grants == 1 && bus_addr_i !== {ea[31:2] + 30'd1, 2'b00}) begin
          mismatch("bus_addr_o", {ea[31:2] + 30'd1, 2'b00}, bus_addr_i);
        end
        if (grants < 2) begin
          covered[4*grants +: 4] = covered[4*grants +: 4] | bus_be_i;
        end
        grants++;
        outstanding++;
      end
      if (bus_rvalid_i) begin
        outstanding--;
      end
      if (outstanding > MAX_OUTSTANDING) begin
        complain("more bus transfers outstanding than the limit allows");
      end

      // Access accepted, so check its transfers and update the model
      if (valid_i && ready_i) begin
        n_exp = (ea[1:0] + bytes > 4) ? 2 : 1;
        if (grants != n_exp) begin
          $display("access at %h took %0d bus transfers instead of %0d", ea, grants, n_exp);
          errors++;
        end
        if (covered !== 8'(((1 << bytes) - 1) << ea[1:0])) begin
          mismatch("bus_be_o", 32'(((1 << bytes) - 1) << ea[1:0]), 32'(covered));
        end
        grants  = 0;
        covered = '0;
        v       = '0;
        for (int k = 0; k < bytes; k++) begin
          if (we_i) begin
            ref_mem[ea[5:0] + k] = wdata_i[8*k +: 8];
          end else begin
            v[8*k +: 8] = ref_mem[ea[5:0] + k];
          end
        end
        // Narrow loads fill the upper bits with the top data bit
        if (!we_i && sext_i && bytes < 4 && v[8*bytes-1]) begin
          v = v | (32'hffff_ffff << (8 * bytes));
        end
        exp_we_q.push_back(we_i);
        exp_data_q.push_back(v);
      end
      idle = (outstanding == 0) && (exp_we_q.size() == 0);
    end
  end

endmodule

// File: testbench/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

  localparam logic [31:0] SEED    = 32'h96cf_e08b;
  localparam int          TIMEOUT = 200;
  localparam int          N_ACC   = 300;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            valid_i;
  logic            we_i;
  lsu_size_e       size_i;
  logic            sext_i;
  logic [XLEN-1:0] base_i;
  logic [XLEN-1:0] offset_i;
  logic [XLEN-1:0] wdata_i;
  logic            ready_o;
  logic            result_valid_o;
  logic [XLEN-1:0] result_rdata_o;
  logic            result_we_o;
  logic            busy_o;
  logic            bus_req_o;
  logic [XLEN-1:0] bus_addr_o;
  logic            bus_we_o;
  logic [BE_W-1:0] bus_be_o;
  logic [XLEN-1:0] bus_wdata_o;
  logic            bus_gnt_i = 1'b0;
  logic            bus_rvalid_i = 1'b0;
  logic [XLEN-1:0] bus_rdata_i = '0;

  logic [31:0] core_st;
  logic [31:0] bus_st;
  int          tb_errors;
  int          accesses;
  int          chk_errors;
  logic        chk_idle;

  // Slave state, sampled at the falling edge
  logic            rst_s = 1'b0;
  logic            req_s = 1'b0;
  logic            acc_s = 1'b0;
  logic            rsp_s = 1'b0;
  logic [XLEN-1:0] addr_s;
  logic            we_s;
  logic [BE_W-1:0] be_s;
  logic [XLEN-1:0] wdata_s;
  logic [7:0]      mem [64];
  logic [XLEN-1:0] rsp_data [$];
  int              rsp_due [$];
  int              gnt_wait;
  int              cyc;

  always #2 clk = ~clk;

  lsu_top DUT (.*);

  lsu_checker u_checker (
    .*,
    .ready_i        ( ready_o        ),
    .result_valid_i ( result_valid_o ),
    .result_rdata_i ( result_rdata_o ),
    .result_we_i    ( result_we_o    ),
    .bus_req_i      ( bus_req_o      ),
    .bus_addr_i     ( bus_addr_o     ),
    .bus_we_i       ( bus_we_o       ),
    .bus_be_i       ( bus_be_o       ),
    .bus_wdata_i    ( bus_wdata_o    ),
    .errors_o       ( chk_errors     ),
    .idle_o         ( chk_idle       )
  );

  //////////////////////////////////////////////////////////////////////
  // Random numbers
  //////////////////////////////////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v  = {v[30:0], st[0]};
      st = lfsr_step(st);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("RESULT: FAIL");
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus slave, in-order responses with random latencies
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    rst_s   = rst_n;
    req_s   = bus_req_o;
    acc_s   = bus_req_o && bus_gnt_i;
    rsp_s   = bus_rvalid_i;
    addr_s  = bus_addr_o;
    we_s    = bus_we_o;
    be_s    = bus_be_o;
    wdata_s = bus_wdata_o;
  end

  always @(posedge clk) begin
    logic [31:0] r;
    logic [31:0] rdata;
    logic [5:0]  word;
    #1;
    if (!rst_s) begin
      for (int a = 0; a < 64; a++) begin
        mem[a] = 8'(a * 37 + 11);
      end
      bus_st   = ~SEED;
      gnt_wait = 0;
      cyc      = 0;
      rsp_data.delete();
      rsp_due.delete();
    end else begin
      // Response handed over at this edge
      if (rsp_s) begin
        void'(rsp_data.pop_front());
        void'(rsp_due.pop_front());
      end
      if (acc_s) begin
        // Only address bits 5..2 select the word inside the window
        word = {addr_s[5:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
          if (we_s && be_s[k]) begin
            mem[word + k] = wdata_s[8*k +: 8];
          end
          rdata[8*k +: 8] = mem[word + k];
        end
        take_bits(bus_st, 2, r);
        rsp_data.push_back(rdata);
        rsp_due.push_back(cyc + 1 + int'(r % 3));
        take_bits(bus_st, 2, r);
        gnt_wait = int'(r % 3);
      end else if (req_s && gnt_wait > 0) begin
        gnt_wait--;
      end
      cyc++;
    end
    bus_gnt_i    = rst_s && (gnt_wait == 0);
    bus_rvalid_i = (rsp_due.size() > 0) && (rsp_due[0] <= cyc);
    bus_rdata_i  = bus_rvalid_i ? rsp_data[0] : '0;
  end

  //////////////////////////////////////////////////////////////////////
  // Core side
  //////////////////////////////////////////////////////////////////////

  // Mode 0 aligned, mode 1 odd offsets for halfwords and words, mode 2 any
  task automatic do_access(input int mode);
    logic [31:0] r;
    logic [31:0] ea;
    logic [31:0] ofs;
    int          bytes;
    int          guard;
    take_bits(core_st, 2, r);
    size_i = lsu_size_e'(2'(r % 3));
    bytes  = 1 << (r % 3);
    take_bits(core_st, 1, r);
    we_i = r[0];
    take_bits(core_st, 1, r);
    sext_i = r[0];
    // Whole access stays inside the 64-byte window
    take_bits(core_st, 6, ea);
    ea = ea % (65 - bytes);
    if (mode == 0) begin
      ea = ea & ~(bytes - 1);
    end
    if (mode == 1 && bytes > 1 && !ea[0]) begin
      ea = (ea == 0) ? 32'd1 : ea - 1;
    end
    take_bits(core_st, 12, r);
    ofs      = {{20{r[11]}}, r[11:0]};
    offset_i = ofs;
    base_i   = ea - ofs;
    take_bits(core_st, 32, wdata_i);
    valid_i = 1'b1;
    guard   = 0;
    do begin
      @(negedge clk);
      guard++;
    end while (!ready_o && guard < TIMEOUT);
    if (!ready_o) stop_on_timeout("ready_o");
    @(posedge clk);
    #1;
    valid_i = 1'b0;
    accesses++;
    // Sometimes leave the core idle for a cycle
    take_bits(core_st, 2, r);
    if (r == 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_test(input string name, input int mode);
    int err0;
    int guard;
    err0 = chk_errors + tb_errors;
    for (int i = 0; i < N_ACC; i++) begin
      do_access(mode);
    end
    guard = 0;
    while (!chk_idle && guard < TIMEOUT) begin
      @(posedge clk);
      #1;
      guard++;
    end
    if (!chk_idle) stop_on_timeout("the last responses");
    if (busy_o) begin
      $display("busy_o still high after all responses with no request");
      tb_errors++;
    end
    $display("test %s: %0d accesses, %0d errors", name, N_ACC, chk_errors + tb_errors - err0);
  endtask

  initial begin
    int total;
    rst_n     = 1'b0;
    valid_i   = 1'b0;
    we_i      = 1'b0;
    size_i    = LSU_BYTE;
    sext_i    = 1'b0;
    base_i    = '0;
    offset_i  = '0;
    wdata_i   = '0;
    core_st   = SEED;
    tb_errors = 0;
    accesses  = 0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    if (bus_req_o || ready_o || result_valid_o || busy_o) begin
      $display("outputs not low after reset");
      tb_errors++;
    end
    run_test("aligned", 0);
    run_test("misaligned", 1);
    run_test("mixed", 2);
    total = chk_errors + tb_errors;
    $display("3 tests, %0d accesses, %0d errors", accesses, total);
    if (total == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  // Core request
  input  logic            valid_i,
  input  logic            we_i,
  input  lsu_size_e       size_i,
  input  logic            sext_i,
  input  logic [XLEN-1:0] base_i,
  input  logic [XLEN-1:0] offset_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic            ready_o,
  // Core result
  output logic            result_valid_o,
  output logic [XLEN-1:0] result_rdata_o,
  output logic            result_we_o,
  output logic            busy_o,
  // Data bus
  output logic            bus_req_o,
  output logic [XLEN-1:0] bus_addr_o,
  output logic            bus_we_o,
  output logic [BE_W-1:0] bus_be_o,
  output logic [XLEN-1:0] bus_wdata_o,
  input  logic            bus_gnt_i,
  input  logic            bus_rvalid_i,
  input  logic [XLEN-1:0] bus_rdata_i
);

  logic             granted;
  logic             req_split;
  logic [OFS_W-1:0] req_offset;

  // Context of the transfer being answered
  logic             ctx_last;
  logic             ctx_we;
  lsu_size_e        ctx_size;
  logic             ctx_sext;
  logic [OFS_W-1:0] ctx_offset;

  // Direction is the same for both phases
  assign bus_we_o = we_i;

  // Address, lanes and store data per phase
  lsu_request u_request (
    .clk       ( clk         ),
    .rst_n     ( rst_n       ),
    .valid_i   ( valid_i     ),
    .we_i      ( we_i        ),
    .size_i    ( size_i      ),
    .sext_i    ( sext_i      ),
    .base_i    ( base_i      ),
    .offset_i  ( offset_i    ),
    .wdata_i   ( wdata_i     ),
    .granted_i ( granted     ),
    .addr_o    ( bus_addr_o  ),
    .be_o      ( bus_be_o    ),
    .wdata_o   ( bus_wdata_o ),
    .split_o   ( req_split   ),
    .second_o  (             ),
    .offset_o  ( req_offset  )
  );

  // Handshake, outstanding limit and response context
  lsu_track u_track (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .valid_i      ( valid_i      ),
    .split_i      ( req_split    ),
    .we_i         ( we_i         ),
    .size_i       ( size_i       ),
    .sext_i       ( sext_i       ),
    .offset_i     ( req_offset   ),
    .bus_gnt_i    ( bus_gnt_i    ),
    .bus_rvalid_i ( bus_rvalid_i ),
    .bus_req_o    ( bus_req_o    ),
    .granted_o    ( granted      ),
    .ready_o      ( ready_o      ),
    .busy_o       ( busy_o       ),
    .ctx_last_o   ( ctx_last     ),
    .ctx_we_o     ( ctx_we       ),
    .ctx_size_o   ( ctx_size     ),
    .ctx_sext_o   ( ctx_sext     ),
    .ctx_offset_o ( ctx_offset   )
  );

  // Load data alignment and result
  lsu_rdata_align u_rdata_align (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .rvalid_i       ( bus_rvalid_i   ),
    .rdata_i        ( bus_rdata_i    ),
    .last_i         ( ctx_last       ),
    .we_i           ( ctx_we         ),
    .size_i         ( ctx_size       ),
    .sext_i         ( ctx_sext       ),
    .offset_i       ( ctx_offset     ),
    .result_valid_o ( result_valid_o ),
    .result_rdata_o ( result_rdata_o ),
    .result_we_o    ( result_we_o    )
  );

endmodule

// File: verilog/lsu_track.sv
`timescale 1ns/1ps

module lsu_track import lsu_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  // Request side
  input  logic             valid_i,
  input  logic             split_i,
  input  logic             we_i,
  input  lsu_size_e        size_i,
  input  logic             sext_i,
  input  logic [OFS_W-1:0] offset_i,
  // Bus handshake
  input  logic             bus_gnt_i,
  input  logic             bus_rvalid_i,
  output logic             bus_req_o,
  output logic             granted_o,
  // Core side
  output logic             ready_o,
  output logic             busy_o,
  // Context of the oldest outstanding transfer
  output logic             ctx_last_o,
  output logic             ctx_we_o,
  output lsu_size_e        ctx_size_o,
  output logic             ctx_sext_o,
  output logic [OFS_W-1:0] ctx_offset_o
);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             wr_ptr_q;
  logic             rd_ptr_q;

  // Context storage, one slot per outstanding transfer
  logic             last_mem   [MAX_OUTSTANDING];
  logic             we_mem     [MAX_OUTSTANDING];
  lsu_size_e        size_mem   [MAX_OUTSTANDING];
  logic             sext_mem   [MAX_OUTSTANDING];
  logic [OFS_W-1:0] offset_mem [MAX_OUTSTANDING];

  //////////////////////////////////////////////////////////////////////
  // Request gating and handshake
  //////////////////////////////////////////////////////////////////////

  // No new transfer once the response queue is full
  assign bus_req_o = valid_i && (cnt_q < CNT_W'(MAX_OUTSTANDING));
  assign granted_o = bus_req_o && bus_gnt_i;

  // Core request done on the grant of its last phase
  assign ready_o = granted_o && !split_i;

  // Transfers in flight, or one still waiting for its grant
  assign busy_o = (cnt_q != '0) || bus_req_o;

  //////////////////////////////////////////////////////////////////////
  // Outstanding counter
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    case ({granted_o, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q    <= '0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      // Two-slot ring, pointers wrap by overflow
      if (granted_o) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (bus_rvalid_i) rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Context FIFO
  //////////////////////////////////////////////////////////////////////

  // Only the first phase of a split access is not the last one
  always_ff @(posedge clk) begin
    if (granted_o) begin
      last_mem[wr_ptr_q]   <= !split_i;
      we_mem[wr_ptr_q]     <= we_i;
      size_mem[wr_ptr_q]   <= size_i;
      sext_mem[wr_ptr_q]   <= sext_i;
      offset_mem[wr_ptr_q] <= offset_i;
    end
  end

  // Responses come back in order, so the read slot is the oldest
  assign ctx_last_o   = last_mem[rd_ptr_q];
  assign ctx_we_o     = we_mem[rd_ptr_q];
  assign ctx_size_o   = size_mem[rd_ptr_q];
  assign ctx_sext_o   = sext_mem[rd_ptr_q];
  assign ctx_offset_o = offset_mem[rd_ptr_q];

endmodule
